// File: hdl/video_pkg.sv
`default_nettype none

package video_pkg;

	//////////////////////////////
	// Widths
	//////////////////////////////

	// One output channel intensity
	localparam int intensity_bits = 8;
	// Colour code per channel, one ladder input
	localparam int code_bits = 4;
	// Colour index from the tile/sprite side
	localparam int index_bits = 8;
	// Bank bit plus index selects one entry
	localparam int entry_addr_bits = index_bits + 1;
	localparam int entries = 1 << entry_addr_bits;

	//////////////////////////////
	// Resistor ladder
	//////////////////////////////

	// Code bit 0 is the weakest leg, bit 3 the strongest
	localparam int res_ohms_0 = 2200;
	localparam int res_ohms_1 = 1000;
	localparam int res_ohms_2 = 470;
	localparam int res_ohms_3 = 220;

	//////////////////////////////
	// Types
	//////////////////////////////

	// Pixel from the video side, no handshake
	typedef struct packed {
		logic [index_bits-1:0] index;
		logic                  bank;
		logic                  blank;
	} pixel_t;

	// Red/green PROM entry, green in the high nibble
	typedef struct packed {
		logic [code_bits-1:0] g;
		logic [code_bits-1:0] r;
	} rg_entry_t;

	// Blue PROM entry
	typedef struct packed {
		logic [code_bits-1:0] b;
	} b_entry_t;

	// Codes into the ladder
	typedef struct packed {
		logic [code_bits-1:0] r;
		logic [code_bits-1:0] g;
		logic [code_bits-1:0] b;
	} code_rgb_t;

	// Final colour out
	typedef struct packed {
		logic [intensity_bits-1:0] r;
		logic [intensity_bits-1:0] g;
		logic [intensity_bits-1:0] b;
	} color_t;

endpackage

`default_nettype wire

// File: hdl/bus_pkg.sv
`default_nettype none

package bus_pkg;

	//////////////////////////////
	// Wishbone classic
	//////////////////////////////

	localparam int adr_bits = 10;
	localparam int dat_bits = 8;

	// Master to slave
	typedef struct packed {
		logic                cyc;
		logic                stb;
		logic                we;
		logic [adr_bits-1:0] adr;
		logic [dat_bits-1:0] dat;
	} wb_req_t;

	// Slave to master, no err or rty
	typedef struct packed {
		logic                ack;
		logic [dat_bits-1:0] dat;
	} wb_rsp_t;

	//////////////////////////////
	// Palette address map
	//////////////////////////////

	// Store select values
	localparam logic sel_rg = 1'b0;
	localparam logic sel_b  = 1'b1;

	// Overlays adr bit for bit
	typedef struct packed {
		logic                             sel;
		logic                             bank;
		logic [video_pkg::index_bits-1:0] index;
	} pal_addr_t;

endpackage

`default_nettype wire

// File: hdl/clut_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module clut_ctrl (
	input  logic                                  clk_6m,
	input  logic                                  reset,
	input  bus_pkg::wb_req_t                      wb_req,
	output bus_pkg::wb_rsp_t                      wb_rsp,
	output logic                                  rg_we,
	output logic                                  b_we,
	output logic [video_pkg::entry_addr_bits-1:0] pal_addr,
	output video_pkg::rg_entry_t                  rg_wdata,
	output video_pkg::b_entry_t                   b_wdata,
	input  video_pkg::rg_entry_t                  rg_rdata,
	input  video_pkg::b_entry_t                   b_rdata
);
	import bus_pkg::*;
	import video_pkg::*;

	// Padding to zero-extend a blue entry onto dat
	localparam int b_pad_bits = dat_bits - $bits(b_entry_t);

	pal_addr_t req_addr;
	logic      req_valid;
	logic      accept;
	logic      ack_q;
	logic      gap;
	logic      rd_sel;

	//////////////////////////////
	// Address decode
	//////////////////////////////

	// adr split as sel, bank, index
	assign req_addr = pal_addr_t'(wb_req.adr);
	assign req_valid = wb_req.cyc && wb_req.stb;

	// Take a new cycle only when idle and not in the gap after ack
	assign accept = req_valid && !ack_q && !gap;

	// Same entry address feeds both stores
	assign pal_addr = {req_addr.bank, req_addr.index};

	//////////////////////////////
	// Store writes
	//////////////////////////////

	// One-cycle strobe, only the selected store
	assign rg_we = accept && wb_req.we && (req_addr.sel == sel_rg);
	assign b_we  = accept && wb_req.we && (req_addr.sel == sel_b);

	// Each store keeps only the bits its entry needs
	assign rg_wdata = rg_entry_t'(wb_req.dat);
	assign b_wdata  = b_entry_t'(wb_req.dat[$bits(b_entry_t)-1:0]);

	//////////////////////////////
	// Ack and gap
	//////////////////////////////

	// ack one cycle after accept, then one dead cycle
	always_ff @(posedge clk_6m) begin
		if (reset) begin
			ack_q <= 1'b0;
			gap   <= 1'b0;
		end else begin
			ack_q <= accept;
			gap   <= ack_q;
		end
	end

	// Which store the accepted cycle targeted
	always_ff @(posedge clk_6m) begin
		if (accept) begin
			rd_sel <= req_addr.sel;
		end
	end

	//////////////////////////////
	// Readback
	//////////////////////////////

	// Store data is registered, so it lines up with ack
	always_comb begin
		wb_rsp.ack = ack_q;
		if (!ack_q) begin
			wb_rsp.dat = '0;
		end else if (rd_sel == sel_b) begin
			// Blue sits in the low nibble
			wb_rsp.dat = {{b_pad_bits{1'b0}}, b_rdata};
		end else begin
			wb_rsp.dat = rg_rdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/palette_ram.sv
`timescale 1ns/1ps
`default_nettype none

module palette_ram #(
	parameter type entry_t = video_pkg::rg_entry_t
) (
	input  logic                                  clk_6m,
	input  logic [video_pkg::entry_addr_bits-1:0] pix_addr,
	output entry_t                                pix_data,
	input  logic                                  bus_we,
	input  logic [video_pkg::entry_addr_bits-1:0] bus_addr,
	input  entry_t                                bus_wdata,
	output entry_t                                bus_rdata
);
	import video_pkg::*;

	// Stands in for one palette PROM
	// Contents survive reset
	entry_t mem [entries];

	//////////////////////////////
	// Pixel port
	//////////////////////////////

	// Registered read, takes the place of the input latch
	// A bus write to the same entry this cycle is not seen yet
	always_ff @(posedge clk_6m) begin
		pix_data <= mem[pix_addr];
	end

	//////////////////////////////
	// Bus port
	//////////////////////////////

	// Read before write
	// Old entry comes back on a write cycle
	always_ff @(posedge clk_6m) begin
		if (bus_we) begin
			mem[bus_addr] <= bus_wdata;
		end
		bus_rdata <= mem[bus_addr];
	end

endmodule

`default_nettype wire

// File: hdl/color_dac.sv
`timescale 1ns/1ps
`default_nettype none

module color_dac (
	input  logic                 clk_6m,
	input  logic                 reset,
	input  video_pkg::code_rgb_t codes,
	input  logic                 blank,
	output video_pkg::color_t    color
);
	import video_pkg::*;

	localparam int levels = 1 << code_bits;
	localparam longint unsigned full_scale = (64'd1 << intensity_bits) - 1;
	// Conductance unit, picosiemens keeps the integer math exact enough
	localparam longint unsigned g_unit = 64'd1_000_000_000_000;

	typedef logic [levels-1:0][intensity_bits-1:0] level_tbl_t;

	//////////////////////////////
	// Ladder table
	//////////////////////////////

	// Conductance of one ladder leg
	function automatic longint unsigned leg_g(input int bit_idx);
		case (bit_idx)
			0: leg_g = g_unit / res_ohms_0;
			1: leg_g = g_unit / res_ohms_1;
			2: leg_g = g_unit / res_ohms_2;
			default: leg_g = g_unit / res_ohms_3;
		endcase
	endfunction

	// Set legs pull up, the rest pull down
	// Output is full scale times G_on over G_total, rounded
	function automatic level_tbl_t build_table();
		level_tbl_t     tbl;
		longint unsigned g_on;
		longint unsigned g_all;
		for (int code = 0; code < levels; code++) begin
			g_on  = 0;
			g_all = 0;
			for (int b = 0; b < code_bits; b++) begin
				g_all += leg_g(b);
				if (code[b]) begin
					g_on += leg_g(b);
				end
			end
			// Add half the divisor to round to nearest
			tbl[code] = intensity_bits'((2 * full_scale * g_on + g_all) / (2 * g_all));
		end
		return tbl;
	endfunction

	// Code 0 gives 0, code 15 gives full scale
	localparam level_tbl_t level_tbl = build_table();

	//////////////////////////////
	// Output stage
	//////////////////////////////

	// Blank lags one cycle to meet the codes from the stores
	logic blank_d;

	always_ff @(posedge clk_6m) begin
		if (reset) begin
			blank_d <= 1'b0;
			color   <= '0;
		end else begin
			blank_d <= blank;
			if (blank_d) begin
				// Black during blanking
				color <= '0;
			end else begin
				color.r <= level_tbl[codes.r];
				color.g <= level_tbl[codes.g];
				color.b <= level_tbl[codes.b];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/clut_top.sv
`timescale 1ns/1ps
`default_nettype none

module clut_top (
	input  logic              clk_6m,
	input  logic              reset,
	input  bus_pkg::wb_req_t  wb_req,
	output bus_pkg::wb_rsp_t  wb_rsp,
	input  video_pkg::pixel_t pixel,
	output video_pkg::color_t color
);
	import video_pkg::*;

	// Bus side
	logic                       rg_we;
	logic                       b_we;
	logic [entry_addr_bits-1:0] pal_addr;
	rg_entry_t                  rg_wdata;
	b_entry_t                   b_wdata;
	rg_entry_t                  rg_rdata;
	b_entry_t                   b_rdata;

	// Pixel side
	logic [entry_addr_bits-1:0] pix_addr;
	rg_entry_t                  rg_pix;
	b_entry_t                   b_pix;
	code_rgb_t                  codes;

	//////////////////////////////
	// Host port
	//////////////////////////////

	clut_ctrl ctrl (
		.clk_6m   (clk_6m),
		.reset    (reset),
		.wb_req   (wb_req),
		.wb_rsp   (wb_rsp),
		.rg_we    (rg_we),
		.b_we     (b_we),
		.pal_addr (pal_addr),
		.rg_wdata (rg_wdata),
		.b_wdata  (b_wdata),
		.rg_rdata (rg_rdata),
		.b_rdata  (b_rdata)
	);

	//////////////////////////////
	// Palette stores
	//////////////////////////////

	// Bank on top, as on the original PROM address
	assign pix_addr = {pixel.bank, pixel.index};

	// Red and green share one store
	palette_ram #(.entry_t(rg_entry_t)) rg_store (
		.clk_6m    (clk_6m),
		.pix_addr  (pix_addr),
		.pix_data  (rg_pix),
		.bus_we    (rg_we),
		.bus_addr  (pal_addr),
		.bus_wdata (rg_wdata),
		.bus_rdata (rg_rdata)
	);

	palette_ram #(.entry_t(b_entry_t)) b_store (
		.clk_6m    (clk_6m),
		.pix_addr  (pix_addr),
		.pix_data  (b_pix),
		.bus_we    (b_we),
		.bus_addr  (pal_addr),
		.bus_wdata (b_wdata),
		.bus_rdata (b_rdata)
	);

	//////////////////////////////
	// Ladder
	//////////////////////////////

	assign codes = '{r: rg_pix.r, g: rg_pix.g, b: b_pix.b};

	// Raw blank in, the delay lives in the converter
	color_dac dac (
		.clk_6m (clk_6m),
		.reset  (reset),
		.codes  (codes),
		.blank  (pixel.blank),
		.color  (color)
	);

endmodule

`default_nettype wire

// File: verification/clut_tb.sv
`timescale 1ns/1ps
`default_nettype none

module clut_tb;
	import bus_pkg::*;
	import video_pkg::*;

	localparam logic [1:0] k_write = 2'd0;
	localparam logic [1:0] k_read  = 2'd1;
	localparam logic [1:0] k_pixel = 2'd2;
	localparam int ack_limit    = 8;
	localparam int settle_limit = 16;

	// One table row
	// Test names are kept in row_names
	typedef struct packed {
		logic [1:0]  kind;
		logic        sel;
		logic        bank;
		logic [7:0]  index;
		logic        blank;
		logic [7:0]  data;
		logic [23:0] expected;
	} row_t;

	logic     clk_6m;
	logic     reset;
	wb_req_t  wb_req;
	wb_rsp_t  wb_rsp;
	pixel_t   pixel;
	color_t   color;

	row_t      rows [$];
	string     row_names [$];
	rg_entry_t rg_shadow [512];
	logic [3:0] b_shadow [512];

	// Colour checks waiting for their cycle
	int          pend_due [$];
	logic [23:0] pend_exp [$];
	string       pend_name [$];

	logic [31:0] lfsr;
	int          cycle;
	int          pass_count;
	int          fail_count;
	logic        timed_out;
	logic        ack_s;
	logic [7:0]  dat_s;
	logic [23:0] color_s;

	clut_top UUT (
		.clk_6m (clk_6m),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp),
		.pixel  (pixel),
		.color  (color)
	);

	// 40 ns period
	always #20 clk_6m = ~clk_6m;

	//////////////////////////////
	// Reference models
	//////////////////////////////

	// Galois LFSR stepped once per bit
	function automatic logic [7:0] take_bits(input int n);
		logic [7:0] val;
		logic       out_bit;
		val = '0;
		for (int i = 0; i < n; i++) begin
			out_bit = lfsr[0];
			lfsr = lfsr >> 1;
			if (out_bit) begin
				lfsr = lfsr ^ 32'h80200003;
			end
			val = {val[6:0], out_bit};
		end
		return val;
	endfunction

	// Ladder with 2200/1000/470/220 ohm legs on bits 0 to 3
	function automatic logic [7:0] ladder(input logic [3:0] code);
		real ohms [4];
		real g_on;
		real g_all;
		ohms = '{2200.0, 1000.0, 470.0, 220.0};
		g_on = 0.0;
		g_all = 0.0;
		for (int b = 0; b < 4; b++) begin
			g_all = g_all + 1.0 / ohms[b];
			if (code[b]) begin
				g_on = g_on + 1.0 / ohms[b];
			end
		end
		return 8'($rtoi(255.0 * g_on / g_all + 0.5));
	endfunction

	function automatic logic [23:0] expected_color(input logic bank, input logic [7:0] index,
			input logic blank);
		rg_entry_t  rg;
		logic [3:0] b;
		rg = rg_shadow[{bank, index}];
		b = b_shadow[{bank, index}];
		if (blank) begin
			return 24'h0;
		end
		return {ladder(rg.r), ladder(rg.g), ladder(b)};
	endfunction

	//////////////////////////////
	// Table building
	//////////////////////////////

	task automatic add_row(input row_t row, input string name);
		rows.push_back(row);
		row_names.push_back(name);
	endtask

	// Shadow follows every write
	// Blue keeps only the low nibble
	task automatic add_write(input logic sel, input logic bank, input logic [7:0] index,
			input logic [7:0] data);
		row_t row;
		row = '{kind: k_write, sel: sel, bank: bank, index: index, blank: 1'b0,
			data: data, expected: 24'h0};
		if (sel) begin
			b_shadow[{bank, index}] = data[3:0];
		end else begin
			rg_shadow[{bank, index}] = rg_entry_t'(data);
		end
		add_row(row, $sformatf("wr_%s_b%0d_%02h", sel ? "b" : "rg", bank, index));
	endtask

	task automatic add_read(input logic sel, input logic bank, input logic [7:0] index);
		row_t row;
		row = '{kind: k_read, sel: sel, bank: bank, index: index, blank: 1'b0,
			data: 8'h0, expected: 24'h0};
		// Zero-extended entry
		if (sel) begin
			row.expected = {20'h0, b_shadow[{bank, index}]};
		end else begin
			row.expected = {16'h0, rg_shadow[{bank, index}]};
		end
		add_row(row, $sformatf("rd_%s_b%0d_%02h", sel ? "b" : "rg", bank, index));
	endtask

	task automatic add_pixel(input logic bank, input logic [7:0] index, input logic blank);
		row_t row;
		row = '{kind: k_pixel, sel: 1'b0, bank: bank, index: index, blank: blank,
			data: 8'h0, expected: expected_color(bank, index, blank)};
		add_row(row, $sformatf("px_%s_b%0d_%02h", blank ? "blank" : "show", bank, index));
	endtask

	task automatic build_table();
		logic [7:0] idx_list [3];
		idx_list = '{8'h05, 8'h3c, 8'ha7};
		// Extreme codes 0 and 15
		// Junk in the upper nibble of blue
		add_write(1'b0, 1'b0, 8'h00, 8'hf0);
		add_write(1'b1, 1'b0, 8'h00, 8'h0f);
		add_write(1'b0, 1'b0, 8'hff, 8'h0f);
		add_write(1'b1, 1'b0, 8'hff, 8'h30);
		for (int i = 0; i < 3; i++) begin
			for (int bk = 0; bk < 2; bk++) begin
				add_write(1'b0, bk[0], idx_list[i], take_bits(8));
				add_write(1'b1, bk[0], idx_list[i], take_bits(8));
			end
		end
		for (int i = 0; i < 3; i++) begin
			for (int bk = 0; bk < 2; bk++) begin
				add_read(1'b0, bk[0], idx_list[i]);
				add_read(1'b1, bk[0], idx_list[i]);
			end
		end
		add_read(1'b1, 1'b0, 8'hff);
		// Back to back pixels
		// Both banks for each index
		add_pixel(1'b0, 8'h00, 1'b0);
		add_pixel(1'b0, 8'hff, 1'b0);
		for (int i = 0; i < 3; i++) begin
			add_pixel(1'b0, idx_list[i], 1'b0);
			add_pixel(1'b1, idx_list[i], 1'b0);
		end
		add_pixel(1'b0, 8'h00, 1'b1);
		add_pixel(1'b1, 8'h3c, 1'b1);
		add_pixel(1'b1, 8'h3c, 1'b0);
	endtask

	//////////////////////////////
	// Drivers and checks
	//////////////////////////////

	task automatic check_value(input string name, input logic [23:0] expected,
			input logic [23:0] actual);
		if (actual !== expected) begin
			$display("FAIL %s expected %06h actual %06h", name, expected, actual);
			fail_count++;
		end else begin
			$display("ok   %s %06h", name, actual);
			pass_count++;
		end
	endtask

	// Sample 1 ns after the edge
	// Return 2 ns after it, ready to drive
	task automatic tick();
		@(posedge clk_6m);
		#1;
		cycle++;
		ack_s = wb_rsp.ack;
		dat_s = wb_rsp.dat;
		color_s = color;
		if (pend_due.size() > 0 && pend_due[0] == cycle) begin
			check_value(pend_name[0], pend_exp[0], color_s);
			pend_due.delete(0);
			pend_exp.delete(0);
			pend_name.delete(0);
		end
		#1;
	endtask

	task automatic bus_cycle(input row_t row, input string name);
		pal_addr_t addr;
		int        waited;
		logic      bad;
		addr.sel = row.sel;
		addr.bank = row.bank;
		addr.index = row.index;
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: row.kind == k_write, adr: addr, dat: row.data};
		waited = 0;
		ack_s = 1'b0;
		bad = 1'b0;
		while (!ack_s && waited < ack_limit) begin
			tick();
			waited++;
		end
		if (!ack_s) begin
			$display("Timeout: no ack for %s", name);
			timed_out = 1'b1;
		end else begin
			if (waited != 1) begin
				$display("FAIL %s ack latency expected 1 actual %0d", name, waited);
				bad = 1'b1;
			end
			if (row.kind == k_read && {16'h0, dat_s} !== row.expected) begin
				$display("FAIL %s expected %02h actual %02h", name, row.expected[7:0], dat_s);
				bad = 1'b1;
			end
			// Master keeps the request up to the edge that samples ack
			tick();
			// ack drops after one cycle even with the request still held
			if (ack_s) begin
				$display("FAIL %s ack width expected 0 actual 1", name);
				bad = 1'b1;
			end
			wb_req = '0;
			// Dead cycle before the next request
			tick();
			if (bad) begin
				fail_count++;
			end else begin
				$display("ok   %s", name);
				pass_count++;
			end
		end
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		int waited;
		clk_6m = 1'b0;
		reset = 1'b1;
		wb_req = '0;
		// Blank until the first pixel row
		pixel = '{index: 8'h0, bank: 1'b0, blank: 1'b1};
		lfsr = 32'h11fd787a;
		cycle = 0;
		pass_count = 0;
		fail_count = 0;
		timed_out = 1'b0;
		build_table();
		repeat (10) @(posedge clk_6m);
		#2;
		reset = 1'b0;
		tick();
		tick();
		check_value("reset_idle_color", 24'h0, color_s);
		check_value("reset_idle_ack", 24'h0, {23'h0, ack_s});
		foreach (rows[i]) begin
			if (timed_out) begin
				break;
			end
			if (rows[i].kind == k_pixel) begin
				pixel = '{index: rows[i].index, bank: rows[i].bank, blank: rows[i].blank};
				// Two edges to the colour output
				pend_due.push_back(cycle + 2);
				pend_exp.push_back(rows[i].expected);
				pend_name.push_back(row_names[i]);
				tick();
			end else begin
				bus_cycle(rows[i], row_names[i]);
			end
		end
		waited = 0;
		while (!timed_out && pend_due.size() > 0 && waited < settle_limit) begin
			tick();
			waited++;
		end
		if (!timed_out && pend_due.size() > 0) begin
			$display("Timeout: colour output checks never came due");
			timed_out = 1'b1;
		end
		$display("Tests passed %0d, failed %0d", pass_count, fail_count);
		if (timed_out || fail_count != 0) begin
			$display("Regression failed");
		end else begin
			$display("Regression passed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
hdl/video_pkg.sv
hdl/bus_pkg.sv
hdl/clut_ctrl.sv
hdl/palette_ram.sv
hdl/color_dac.sv
hdl/clut_top.sv
verification/clut_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the palette testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f flist.f \
	--top-module clut_tb \
	-Mdir obj_dir

out=$(./obj_dir/Vclut_tb)
echo "$out"

if echo "$out" | grep -q "^Regression passed$"; then
	exit 0
else
	echo "Simulation did not report a pass"
	exit 1
fi
